//--- mips_decoder.f
+incdir+hw
hw/mips_decoder_pkg.sv
hw/instr_class_decode.sv
hw/alu_op_select.sv
hw/branch_resolve.sv
hw/mips_decoder.sv
test/mips_decoder_properties.sv
test/mips_decoder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator.
# Exits non-zero if the build fails, the run fails, or the log reports failures.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mips_decoder_sim
LOG_FILE=sim.log
FAIL_TEXT="Test failures found"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f mips_decoder.f --top-module mips_decoder_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
	echo "Simulation reported failures"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- test/mips_decoder_tb.sv
// Self-checking testbench for the registered decoder, one result per clock.
// Expected values come from ref_decode, one cycle behind the inputs.
`timescale 1ns/1ps

`include "mips_decoder_consts.svh"

module mips_decoder_tb import mips_decoder_pkg::*; ();

	// --------------------------------------------------
	// Run length and timeout
	// --------------------------------------------------
	localparam int N_RESET       = 4;
	localparam int N_MEM_IMM     = 40;
	localparam int N_BRANCH      = 32;
	localparam int N_RTYPE       = 64;
	localparam int N_JUMP        = 16;
	localparam int N_RANDOM      = 2000;
	localparam int TOTAL_VECTORS = N_RESET + N_MEM_IMM + N_BRANCH + N_RTYPE + N_JUMP + N_RANDOM;
	localparam int TIMEOUT_CYCLES = TOTAL_VECTORS + 50;
	localparam logic [31:0] RAND_SEED = 32'h2e98_358b;

	logic                      clk;
	logic                      reset;
	logic [`MIPS_OPCODE_W-1:0] opcode;
	logic [`MIPS_FUNCT_W-1:0]  funct;
	cmp_flags_t                flags;
	decode_out_t               dec;

	// One-entry expected register, matches the output stage
	decode_out_t               exp_dec;
	logic                      exp_valid = 1'b0;
	logic [`MIPS_OPCODE_W-1:0] exp_opcode;
	logic [`MIPS_FUNCT_W-1:0]  exp_funct;
	int                        cycle_count = 0;
	logic [5:0]                mem_imm_ops [10];

	mips_decoder DUT (
		.clk    (clk),
		.reset  (reset),
		.opcode (opcode),
		.funct  (funct),
		.flags  (flags),
		.dec    (dec)
	);

	// 10 ns clock
	initial clk = 1'b0;
	always #5 clk = ~clk;

	// --------------------------------------------------
	// Reference decode from the opcode tree
	// --------------------------------------------------
	function automatic decode_out_t ref_decode(input logic [5:0] op, input logic [5:0] fn,
			input cmp_flags_t f);
		decode_out_t r;
		r = '0;
		r.alu_op = ALU_ADD;
		if (op[5]) begin
			if (op[3]) begin
				r.ctrl.mem_write = 1'b1;
			end else begin
				r.ctrl.dest_rt = 1'b1;
				r.ctrl.reg_write = 1'b1;
			end
		end else if (op[3]) begin
			r.ctrl.dest_rt = 1'b1;
			r.ctrl.wb_from_alu = 1'b1;
			r.ctrl.reg_write = 1'b1;
			r.slt_select = 1'b1;
			if (op[2:0] == 3'd4) r.alu_op = ALU_AND;
			else if (op[2:0] == 3'd5) r.alu_op = ALU_OR;
			else if (op[2:0] == 3'd6) r.alu_op = ALU_XOR;
			// SLTI and SLTIU pass rs_greater through
			if (op[2:0] == 3'd2 || op[2:0] == 3'd3) r.slt_bit = f.rs_greater;
		end else if (op[2]) begin
			r.ctrl.alu_src_reg = 1'b1;
			r.ctrl.dest_rt = 1'b1;
			r.ctrl.wb_from_alu = 1'b1;
			r.alu_op = ALU_COMP;
			if (op[1:0] == 2'd0) r.ctrl.pc_redirect = f.equal;
			else if (op[1:0] == 2'd1) r.ctrl.pc_redirect = !f.equal;
			else if (op[1:0] == 2'd2) r.ctrl.pc_redirect = f.equal | f.rs_less;
			else r.ctrl.pc_redirect = !(f.equal | f.rs_less);
		end else if (op[1:0] == 2'b00) begin
			r.ctrl.r_format = 1'b1;
			r.ctrl.alu_src_reg = 1'b1;
			r.ctrl.wb_from_alu = 1'b1;
			r.ctrl.reg_write = 1'b1;
			if (fn[5]) begin
				r.slt_select = 1'b1;
				// funct 2 is SUB here too
				if (fn[2:1] == 2'b01) r.alu_op = ALU_SUB;
				else if (fn[2:0] == 3'd4) r.alu_op = ALU_AND;
				else if (fn[2:0] == 3'd5) r.alu_op = ALU_OR;
				else if (fn[2:0] == 3'd6) r.alu_op = ALU_XOR;
				else if (fn[2:0] == 3'd7) r.alu_op = ALU_NOR;
			end else if (fn[1:0] == 2'd0) begin
				r.alu_op = ALU_LSH;
			end else if (fn[1:0] == 2'd2) begin
				r.alu_op = ALU_RSH;
			end
		end else begin
			// J and JAL
			r.ctrl.pc_redirect = 1'b1;
			r.ctrl.pc_absolute = 1'b1;
		end
		return r;
	endfunction

	// --------------------------------------------------
	// Failure handling and compare tasks
	// --------------------------------------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Run stopped on first error");
	endtask

	task automatic check_ctrl(input ctrl_word_t got, input ctrl_word_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0d ns: %s ctrl got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_alu(input alu_op_e got_op, input logic got_sel, input logic got_bit,
			input alu_op_e exp_op, input logic exp_sel, input logic exp_bit, input string what);
		if (got_op !== exp_op) begin
			abort_run($sformatf("Fail at %0d ns: %s alu_op got %0d expected %0d",
				$time, what, got_op, exp_op));
		end
		if (got_sel !== exp_sel || got_bit !== exp_bit) begin
			abort_run($sformatf("Fail at %0d ns: %s slt select/bit got %b%b expected %b%b",
				$time, what, got_sel, got_bit, exp_sel, exp_bit));
		end
	endtask

	// Inputs are stable at the edge, so capture them there
	always @(posedge clk) begin
		if (reset) begin
			exp_dec <= '0;
		end else begin
			exp_dec <= ref_decode(opcode, funct, flags);
		end
		exp_opcode <= opcode;
		exp_funct  <= funct;
		exp_valid  <= 1'b1;
	end

	// Compare mid-cycle, away from the output update
	always @(negedge clk) begin
		if (exp_valid) begin
			check_ctrl(dec.ctrl, exp_dec.ctrl,
				$sformatf("opcode %h funct %h", exp_opcode, exp_funct));
			check_alu(dec.alu_op, dec.slt_select, dec.slt_bit,
				exp_dec.alu_op, exp_dec.slt_select, exp_dec.slt_bit,
				$sformatf("opcode %h funct %h", exp_opcode, exp_funct));
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	function automatic logic [5:0] random_field();
		logic [31:0] w;
		w = $urandom();
		return w[5:0];
	endfunction

	function automatic cmp_flags_t random_flags();
		logic [31:0] w;
		w = $urandom();
		return cmp_flags_t'(w[2:0]);
	endfunction

	// New inputs 1 ns after the edge
	task automatic apply_vector(input logic [5:0] op, input logic [5:0] fn, input cmp_flags_t fl);
		@(posedge clk);
		#1;
		opcode = op;
		funct  = fn;
		flags  = fl;
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		reset  = 1'b1;
		opcode = '0;
		funct  = '0;
		flags  = '0;
		// LW, SW, then ADDI through LUI
		mem_imm_ops = '{6'h23, 6'h2b, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
		repeat (N_RESET) @(posedge clk);
		#1;
		reset = 1'b0;
		check_ctrl(dec.ctrl, '0, "after reset");
		check_alu(dec.alu_op, dec.slt_select, dec.slt_bit, ALU_ADD, 1'b0, 1'b0, "after reset");

		// Memory and immediate group, random rs_greater
		for (int i = 0; i < 10; i++) begin
			for (int n = 0; n < 4; n++) begin
				apply_vector(mem_imm_ops[i], random_field(), random_flags());
			end
		end

		// Every branch kind against all flag patterns
		for (int k = 0; k < 4; k++) begin
			for (int c = 0; c < 8; c++) begin
				apply_vector(6'(4 + k), random_field(), cmp_flags_t'(3'(c)));
			end
		end

		// SPECIAL opcode, full funct sweep
		for (int fn = 0; fn < 64; fn++) begin
			apply_vector(6'h00, 6'(fn), random_flags());
		end

		// J and JAL
		for (int j = 0; j < 2; j++) begin
			for (int c = 0; c < 8; c++) begin
				apply_vector(6'(2 + j), random_field(), cmp_flags_t'(3'(c)));
			end
		end

		// Back-to-back random vectors
		for (int n = 0; n < N_RANDOM; n++) begin
			apply_vector(random_field(), random_field(), random_flags());
		end

		// Let the last result reach the compare
		repeat (2) @(posedge clk);
		@(negedge clk);
		#1;
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- test/mips_decoder_properties.sv
// Bound checks on the decoder output register.
// Assumes reset is held for at least one rising edge.
`timescale 1ns/1ps

module mips_decoder_properties import mips_decoder_pkg::*; (
	input logic        clk,
	input logic        reset,
	input decode_out_t dec
);

	// --------------------------------------------------
	// Reset state
	// --------------------------------------------------

	// Whole output clears one edge after reset
	reset_clears_dec: assert property (
		@(posedge clk) reset |=> (dec == '0)
	) else $error("dec not zero on the cycle after reset");

	// --------------------------------------------------
	// Control word invariants
	// --------------------------------------------------

	// Store never writes the register file
	no_dual_write: assert property (
		@(posedge clk) disable iff (reset)
		!(dec.ctrl.mem_write && dec.ctrl.reg_write)
	) else $error("mem_write and reg_write set together");

	// Store address comes from an add
	store_uses_add: assert property (
		@(posedge clk) disable iff (reset)
		dec.ctrl.mem_write |-> (dec.alu_op == ALU_ADD)
	) else $error("mem_write with alu_op other than ALU_ADD");

endmodule

bind mips_decoder mips_decoder_properties u_props (
	.clk   (clk),
	.reset (reset),
	.dec   (dec)
);

//--- hw/mips_decoder.sv
// Registered MIPS decoder. One instruction per clock, one cycle latency.
// JAL does not write GPR 31 here.
`timescale 1ns/1ps

`include "mips_decoder_consts.svh"

module mips_decoder import mips_decoder_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`MIPS_OPCODE_W-1:0] opcode,
	input  logic [`MIPS_FUNCT_W-1:0]  funct,
	input  cmp_flags_t                flags,
	output decode_out_t               dec
);

	instr_class_e              cls_raw;
	instr_class_e              cls;
	logic [`MIPS_OP_LOW_W-1:0] op_low;
	branch_kind_e              kind;
	alu_op_e                   alu_op;
	logic                      pc_redirect;
	logic                      pc_absolute;
	decode_out_t               dec_next;

	assign op_low = opcode[`MIPS_OP_LOW_W-1:0];
	assign kind   = branch_kind_e'(opcode[1:0]);

	// --------------------------------------------------
	// Sub decoders
	// --------------------------------------------------
	instr_class_decode u_class (
		.opcode (opcode),
		.cls    (cls_raw)
	);

	alu_op_select u_alu_op (
		.cls    (cls_raw),
		.op_low (op_low),
		.funct  (funct),
		.alu_op (alu_op)
	);

	branch_resolve u_branch (
		.cls         (cls_raw),
		.kind        (kind),
		.flags       (flags),
		.pc_redirect (pc_redirect),
		.pc_absolute (pc_absolute)
	);

	// Shifts split off SPECIAL by funct[5]
	assign cls = (cls_raw == CLS_RTYPE && !funct[`MIPS_FUNCT_ALU_BIT]) ? CLS_SHIFT : cls_raw;

	// --------------------------------------------------
	// Control word per class
	// --------------------------------------------------
	always_comb begin
		dec_next = '0;
		dec_next.alu_op = alu_op;
		dec_next.ctrl.pc_redirect = pc_redirect;
		dec_next.ctrl.pc_absolute = pc_absolute;
		case (cls)
			CLS_STORE: begin
				dec_next.ctrl.mem_write = 1'b1;
			end
			CLS_LOAD: begin
				// Writeback from memory into rt
				dec_next.ctrl.dest_rt   = 1'b1;
				dec_next.ctrl.reg_write = 1'b1;
			end
			CLS_IMM: begin
				dec_next.ctrl.dest_rt     = 1'b1;
				dec_next.ctrl.wb_from_alu = 1'b1;
				dec_next.ctrl.reg_write   = 1'b1;
				dec_next.slt_select       = 1'b1;
				// Only SLTI and SLTIU carry a compare result
				dec_next.slt_bit = (op_low[2:1] == 2'b01) && flags.rs_greater;
			end
			CLS_BRANCH: begin
				// rt feeds the compare, nothing is written
				dec_next.ctrl.alu_src_reg = 1'b1;
				dec_next.ctrl.dest_rt     = 1'b1;
				dec_next.ctrl.wb_from_alu = 1'b1;
			end
			CLS_SHIFT, CLS_RTYPE: begin
				dec_next.ctrl.r_format    = 1'b1;
				dec_next.ctrl.alu_src_reg = 1'b1;
				dec_next.ctrl.wb_from_alu = 1'b1;
				dec_next.ctrl.reg_write   = 1'b1;
				// Shifts leave the slt path off
				dec_next.slt_select = (cls == CLS_RTYPE);
			end
			default: begin
				// J and JAL, redirect fields only
			end
		endcase
	end

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			dec <= '0;
		end else begin
			dec <= dec_next;
		end
	end

endmodule

//--- hw/branch_resolve.sv
// PC redirect decision for branches and jumps.
// Flags must be valid in the same cycle as the opcode.
`timescale 1ns/1ps

module branch_resolve import mips_decoder_pkg::*; (
	input  instr_class_e cls,
	input  branch_kind_e kind,
	input  cmp_flags_t   flags,
	output logic         pc_redirect,
	output logic         pc_absolute
);

	// --------------------------------------------------
	// Branch condition per kind
	// --------------------------------------------------
	logic taken;

	always_comb begin
		case (kind)
			BR_EQ:   taken = flags.equal;
			BR_NE:   taken = !flags.equal;
			// rs <= 0
			BR_LEZ:  taken = flags.equal || flags.rs_less;
			// rs > 0
			default: taken = !flags.equal && !flags.rs_less;
		endcase
	end

	// Jumps always redirect, absolute target
	always_comb begin
		case (cls)
			CLS_BRANCH: begin
				pc_redirect = taken;
				pc_absolute = 1'b0;
			end
			CLS_JAL, CLS_JUMP: begin
				pc_redirect = 1'b1;
				pc_absolute = 1'b1;
			end
			default: begin
				pc_redirect = 1'b0;
				pc_absolute = 1'b0;
			end
		endcase
	end

endmodule

//--- hw/alu_op_select.sv
// ALU operation select. SLTI/SLTIU keep ALU_ADD since the compare result
// comes from the datapath flags, not the ALU.
`timescale 1ns/1ps

`include "mips_decoder_consts.svh"

module alu_op_select import mips_decoder_pkg::*; (
	input  instr_class_e              cls,
	input  logic [`MIPS_OP_LOW_W-1:0] op_low,
	input  logic [`MIPS_FUNCT_W-1:0]  funct,
	output alu_op_e                   alu_op
);

	// Immediate group by opcode[2:0]
	function automatic alu_op_e imm_op(input logic [`MIPS_OP_LOW_W-1:0] sel);
		case (sel)
			3'd4:    imm_op = ALU_AND;
			3'd5:    imm_op = ALU_OR;
			3'd6:    imm_op = ALU_XOR;
			// ADDI, ADDIU, SLTI, SLTIU, LUI
			default: imm_op = ALU_ADD;
		endcase
	endfunction

	// R-type ALU group by funct[2:0]
	function automatic alu_op_e rtype_op(input logic [2:0] sel);
		case (sel)
			3'd0, 3'd1: rtype_op = ALU_ADD;
			// funct 2 taken as SUB, as the original decode does
			3'd2, 3'd3: rtype_op = ALU_SUB;
			3'd4:       rtype_op = ALU_AND;
			3'd5:       rtype_op = ALU_OR;
			3'd6:       rtype_op = ALU_XOR;
			default:    rtype_op = ALU_NOR;
		endcase
	endfunction

	// Shifts by funct[1:0]
	function automatic alu_op_e shift_op(input logic [1:0] sel);
		case (sel)
			2'd0:    shift_op = ALU_LSH;
			2'd2:    shift_op = ALU_RSH;
			// SRA and the rest fall back to add
			default: shift_op = ALU_ADD;
		endcase
	endfunction

	// --------------------------------------------------
	// Class mux
	// --------------------------------------------------
	always_comb begin
		case (cls)
			CLS_IMM: begin
				alu_op = imm_op(op_low);
			end
			CLS_BRANCH: begin
				// Compare drives the flags
				alu_op = ALU_COMP;
			end
			CLS_RTYPE, CLS_SHIFT: begin
				if (funct[`MIPS_FUNCT_ALU_BIT]) begin
					alu_op = rtype_op(funct[2:0]);
				end else begin
					alu_op = shift_op(funct[1:0]);
				end
			end
			default: begin
				// Load and store address add, jumps
				alu_op = ALU_ADD;
			end
		endcase
	end

endmodule

//--- hw/instr_class_decode.sv
// Opcode-only class decode. Special opcode always reports CLS_RTYPE;
// the caller splits shifts off using funct.
`timescale 1ns/1ps

`include "mips_decoder_consts.svh"

module instr_class_decode import mips_decoder_pkg::*; (
	input  logic [`MIPS_OPCODE_W-1:0] opcode,
	output instr_class_e              cls
);

	// --------------------------------------------------
	// Opcode tree, first match wins
	// --------------------------------------------------
	always_comb begin
		if (opcode[`MIPS_OP_MEM_BIT]) begin
			// Memory access, bit 3 marks the store
			if (opcode[`MIPS_OP_STORE_BIT]) begin
				cls = CLS_STORE;
			end else begin
				cls = CLS_LOAD;
			end
		end else if (opcode[`MIPS_OP_IMM_BIT]) begin
			// ADDI through LUI, SLTI and SLTIU included
			cls = CLS_IMM;
		end else if (opcode[`MIPS_OP_BRANCH_BIT]) begin
			// BEQ, BNE, BLEZ, BGTZ
			cls = CLS_BRANCH;
		end else if (opcode[1:0] == 2'b00) begin
			// SPECIAL opcode
			cls = CLS_RTYPE;
		end else if (opcode[`MIPS_OP_LINK_BIT]) begin
			cls = CLS_JAL;
		end else begin
			cls = CLS_JUMP;
		end
	end

endmodule

//--- hw/mips_decoder_pkg.sv
// Types shared by the decoder RTL and its testbench.
// alu_op_e must track the ALU's own operation encoding.
package mips_decoder_pkg;

`include "mips_decoder_consts.svh"

	// --------------------------------------------------
	// ALU operation, same numbering as the ALU
	// --------------------------------------------------
	typedef enum logic [`MIPS_ALU_OP_W-1:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_LSH  = 4'd5,
		ALU_RSH  = 4'd6,
		ALU_NOR  = 4'd8,
		ALU_COMP = 4'd11
	} alu_op_e;

	// Instruction class from the opcode tree
	typedef enum logic [2:0] {
		CLS_LOAD,
		CLS_STORE,
		CLS_IMM,
		CLS_BRANCH,
		CLS_SHIFT,
		CLS_RTYPE,
		CLS_JAL,
		CLS_JUMP
	} instr_class_e;

	// Branch kind, taken straight from opcode[1:0]
	typedef enum logic [1:0] {
		BR_EQ  = 2'd0,
		BR_NE  = 2'd1,
		BR_LEZ = 2'd2,
		BR_GTZ = 2'd3
	} branch_kind_e;

	// Compare results from the datapath
	typedef struct packed {
		logic equal;      // rs == rt
		logic rs_greater; // SLTI and SLTIU
		logic rs_less;    // BLEZ and BGTZ
	} cmp_flags_t;

	// --------------------------------------------------
	// Control word, MSB first as the old ctrol vector
	// --------------------------------------------------
	typedef struct packed {
		logic pc_redirect;  // Take new PC
		logic pc_absolute;  // Jump target, not PC relative
		logic r_format;     // R-type instruction
		logic alu_src_reg;  // Second operand from rt
		logic dest_rt;      // Write rt, not rd
		logic wb_from_alu;  // Writeback from ALU, not memory
		logic reg_write;    // Register file write enable
		logic mem_write;    // Data memory write enable
	} ctrl_word_t;

	// Full registered decode result
	typedef struct packed {
		ctrl_word_t ctrl;
		alu_op_e    alu_op;
		logic       slt_select; // Writeback takes slt_bit path
		logic       slt_bit;    // Set-less-than result
	} decode_out_t;

endpackage

//--- hw/mips_decoder_consts.svh
// Field widths and fixed bit positions of the MIPS opcode and function fields.
// Positions assume the classic 6-bit opcode and funct layout.
`ifndef MIPS_DECODER_CONSTS_SVH
`define MIPS_DECODER_CONSTS_SVH

// Field widths
`define MIPS_OPCODE_W 6
`define MIPS_FUNCT_W 6
`define MIPS_ALU_OP_W 4

// Low opcode bits that pick the immediate operation
`define MIPS_OP_LOW_W 3

// Opcode tree bits, tested in this order
`define MIPS_OP_MEM_BIT 5
`define MIPS_OP_STORE_BIT 3
`define MIPS_OP_IMM_BIT 3
`define MIPS_OP_BRANCH_BIT 2
`define MIPS_OP_LINK_BIT 0

// Funct bit that splits ALU ops from shifts
`define MIPS_FUNCT_ALU_BIT 5

`endif
